/* all.f */
+incdir+.
gb80_bus_pkg.sv
interrupt_ctrl.sv
high_ram.sv
bus_router.sv
gb80_bus_top.sv
tb_gb80_bus.sv

/* Bender.yml */
package:
  name: gb80_bus

sources:
  - include_dirs:
      - .
    files:
      - gb80_bus_pkg.sv
      - interrupt_ctrl.sv
      - high_ram.sv
      - bus_router.sv
      - gb80_bus_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_gb80_bus.sv

/* tb_gb80_bus.sv */
`include "gb80_bus_settings.svh"

module tb_gb80_bus import gb80_bus_pkg::*; ();

   logic       clock;
   logic       reset;
   cpu_req_t   cpu_req;
   logic       cpu_mem_disable;
   logic [7:0] ext_rdata;
   int_bits_t  irq;
   logic       int_ack;
   ext_bus_t   ext_bus;
   logic [7:0] rdata;
   region_t    region;
   logic       int_pending;
   logic [7:0] int_vector;

   // Reference state
   logic [7:0] ext_mem [65536];
   logic [7:0] hram_model [`GB80_HIGH_DEPTH];
   logic [4:0] if_model;
   logic [4:0] ie_model;
   logic [7:0] exp_rdata;

   integer     seed;
   string      test_name;
   int         error_count;
   int         timeout_count;

   gb80_bus_top uut (
      .clock           (clock),
      .reset           (reset),
      .cpu_req         (cpu_req),
      .cpu_mem_disable (cpu_mem_disable),
      .ext_rdata       (ext_rdata),
      .irq             (irq),
      .int_ack         (int_ack),
      .ext_bus         (ext_bus),
      .rdata           (rdata),
      .region          (region),
      .int_pending     (int_pending),
      .int_vector      (int_vector)
   );

   initial begin
      clock = 1'b0;
      forever #2 clock = ~clock;
   end

   // External memory answers in the strobe cycle
   assign ext_rdata = ext_mem[ext_bus.addr];

   always @(posedge clock) begin
      if (ext_bus.we) begin
         ext_mem[ext_bus.addr] <= ext_bus.wdata;
      end
   end

   function automatic region_t region_of(input logic [15:0] a);
      if (a == `GB80_MMIO_IE) return REGION_IE;
      if (a == `GB80_MMIO_IF) return REGION_IF;
      if (a >= `GB80_HIGH_START && a <= `GB80_HIGH_END) return REGION_HIGH;
      return REGION_EXTERNAL;
   endfunction

   // One-hot of the lowest set bit
   function automatic logic [4:0] lowest_bit(input logic [4:0] v);
      return v & (~v + 5'd1);
   endfunction

   function automatic logic [7:0] vector_for(input logic [4:0] v);
      for (int i = 0; i < 5; i++) begin
         if (v[i]) return `GB80_INT_VECTOR_BASE + 8'(8 * i);
      end
      return `GB80_INT_VECTOR_BASE;
   endfunction

   function automatic logic [7:0] read_value(input logic [15:0] a);
      case (region_of(a))
         REGION_HIGH: return hram_model[a - `GB80_HIGH_START];
         REGION_IF: return {3'b000, if_model};
         REGION_IE: return {3'b000, ie_model};
         default: return cpu_mem_disable ? 8'h00 : ext_mem[a];
      endcase
   endfunction

   task automatic report_mismatch(input string what, input logic [15:0] exp,
                                  input logic [15:0] act);
      error_count++;
      $display("mismatch %s %s: expected %h, actual %h", test_name, what, exp, act);
   endtask

   // Register and RAM model updated at the same edges as the DUT
   always @(posedge clock or posedge reset) begin : model_update
      logic [4:0] flags_after;
      if (reset) begin
         if_model <= 5'h00;
         ie_model <= 5'h00;
      end else begin
         flags_after = if_model;
         if (cpu_req.write && region_of(cpu_req.addr.word) == REGION_IF) begin
            flags_after = cpu_req.wdata[4:0];
         end else if (int_ack) begin
            flags_after = if_model & ~lowest_bit(if_model & ie_model);
         end
         if_model <= flags_after | irq;
         if (cpu_req.write && region_of(cpu_req.addr.word) == REGION_IE) begin
            ie_model <= cpu_req.wdata[4:0];
         end
         if (cpu_req.write && region_of(cpu_req.addr.word) == REGION_HIGH) begin
            hram_model[cpu_req.addr.word - `GB80_HIGH_START] <= cpu_req.wdata;
         end
      end
   end

   // Outputs sampled mid-cycle while inputs change on the rising edge
   always @(negedge clock) begin : monitor
      logic ext_live;
      // Unknown reset at time zero counts as reset
      if (reset !== 1'b0) begin
         exp_rdata = 8'h00;
      end else begin
         ext_live = region_of(cpu_req.addr.word) == REGION_EXTERNAL && !cpu_mem_disable;
         assert (rdata == exp_rdata) else report_mismatch("rdata", exp_rdata, rdata);
         assert (region == region_of(cpu_req.addr.word))
            else report_mismatch("region", region_of(cpu_req.addr.word), region);
         assert (ext_bus.we == (cpu_req.write && ext_live))
            else report_mismatch("ext we", cpu_req.write && ext_live, ext_bus.we);
         assert (ext_bus.re == (cpu_req.read && ext_live))
            else report_mismatch("ext re", cpu_req.read && ext_live, ext_bus.re);
         if (cpu_req.write && ext_live) begin
            assert (ext_bus.addr == cpu_req.addr.word)
               else report_mismatch("ext addr", cpu_req.addr.word, ext_bus.addr);
            assert (ext_bus.wdata == cpu_req.wdata)
               else report_mismatch("ext wdata", cpu_req.wdata, ext_bus.wdata);
         end
         assert (int_pending == |(if_model & ie_model))
            else report_mismatch("pending", |(if_model & ie_model), int_pending);
         assert (int_vector == vector_for(if_model & ie_model))
            else report_mismatch("vector", vector_for(if_model & ie_model), int_vector);
         // Result lands in the buffer at the next edge
         if (cpu_req.read) begin
            exp_rdata = read_value(cpu_req.addr.word);
         end
      end
   end

   task automatic drive(input cpu_req_t req, input int_bits_t bits, input logic ack);
      @(posedge clock);
      cpu_req <= req;
      irq <= bits;
      int_ack <= ack;
   endtask

   task automatic write_byte(input logic [15:0] a, input logic [7:0] d);
      cpu_req_t req;
      req = '0;
      req.addr.word = a;
      req.wdata = d;
      req.write = 1'b1;
      drive(req, '0, 1'b0);
   endtask

   task automatic read_byte(input logic [15:0] a);
      cpu_req_t req;
      req = '0;
      req.addr.word = a;
      req.read = 1'b1;
      drive(req, '0, 1'b0);
   endtask

   task automatic idle_cycle();
      drive('0, '0, 1'b0);
   endtask

   task automatic raise_irq(input int_bits_t bits);
      drive('0, bits, 1'b0);
   endtask

   task automatic ack_interrupt();
      drive('0, '0, 1'b1);
   endtask

   task automatic set_mem_disable(input logic v);
      @(posedge clock);
      cpu_mem_disable <= v;
      cpu_req <= '0;
   endtask

   initial begin : stimulus
      int         order [`GB80_HIGH_DEPTH];
      int         j;
      int         tmp;
      int         drain_count;
      logic [31:0] rnd;
      logic [15:0] ext_addr;
      logic [7:0]  vec_expected;
      seed = 32'hca65_b2b8;
      error_count = 0;
      timeout_count = 0;
      test_name = "reset";
      reset = 1'b1;
      cpu_req = '0;
      cpu_mem_disable = 1'b0;
      irq = '0;
      int_ack = 1'b0;
      // Fill depends on both address bytes
      for (int i = 0; i < 65536; i++) begin
         ext_mem[i] = i[7:0] ^ i[15:8] ^ 8'h3c;
      end
      for (int i = 0; i < 8; i++) begin
         @(posedge clock);
      end
      reset <= 1'b0;

      @(negedge clock);
      assert (rdata == 8'h00 && !int_pending && !ext_bus.we && !ext_bus.re)
         else begin
            error_count++;
            $display("outputs not cleared by reset");
         end
      read_byte(`GB80_MMIO_IF);
      read_byte(`GB80_MMIO_IE);
      idle_cycle();

      test_name = "high ram";
      for (int i = 0; i < `GB80_HIGH_DEPTH; i++) begin
         rnd = $random(seed);
         write_byte(16'(`GB80_HIGH_START + i), rnd[7:0]);
         order[i] = i;
      end
      // Shuffled read order
      for (int i = `GB80_HIGH_DEPTH - 1; i > 0; i--) begin
         rnd = $random(seed);
         j = int'(rnd[15:0]) % (i + 1);
         tmp = order[i];
         order[i] = order[j];
         order[j] = tmp;
      end
      for (int i = 0; i < `GB80_HIGH_DEPTH; i++) begin
         read_byte(16'(`GB80_HIGH_START + order[i]));
      end
      idle_cycle();

      test_name = "external";
      for (int i = 0; i < 16; i++) begin
         rnd = $random(seed);
         ext_addr = {1'b0, rnd[30:16]};
         write_byte(ext_addr, rnd[7:0]);
         read_byte(ext_addr);
         read_byte(ext_addr ^ 16'h0155);
      end
      set_mem_disable(1'b1);
      write_byte(16'h1234, 8'ha5);
      read_byte(16'h1234);
      read_byte(16'h4321);
      set_mem_disable(1'b0);
      read_byte(16'h1234);
      idle_cycle();

      test_name = "priority";
      for (int i = 0; i < 40; i++) begin
         rnd = $random(seed);
         write_byte(`GB80_MMIO_IE, rnd[7:0]);
         raise_irq(int_bits_t'(rnd[12:8]));
         idle_cycle();
         if (rnd[20]) begin
            write_byte(`GB80_MMIO_IF, 8'h00);
         end
         read_byte(`GB80_MMIO_IF);
      end

      test_name = "acknowledge";
      write_byte(`GB80_MMIO_IF, 8'hf5);
      read_byte(`GB80_MMIO_IF);
      idle_cycle();
      // Nothing enabled, so the ack is ignored
      write_byte(`GB80_MMIO_IE, 8'h00);
      ack_interrupt();
      read_byte(`GB80_MMIO_IF);
      write_byte(`GB80_MMIO_IE, 8'h0a);
      read_byte(`GB80_MMIO_IE);
      read_byte(`GB80_HIGH_END);
      // Vblank flagged but not enabled
      write_byte(`GB80_MMIO_IE, 8'h1e);
      write_byte(`GB80_MMIO_IF, 8'h1f);
      idle_cycle();

      // Drain the four enabled sources in priority order
      drain_count = 0;
      vec_expected = `GB80_INT_VECTOR_BASE + 8'd8;
      @(negedge clock);
      while (int_pending && drain_count < 10) begin
         assert (int_vector == vec_expected)
            else report_mismatch("drain order", vec_expected, int_vector);
         ack_interrupt();
         idle_cycle();
         @(negedge clock);
         vec_expected = vec_expected + 8'd8;
         drain_count++;
      end
      if (int_pending) begin
         timeout_count++;
         $display("timeout: interrupts still pending after %0d acknowledges", drain_count);
      end
      assert (drain_count == 4) else report_mismatch("drain count", 4, drain_count);
      // Only the disabled vblank flag is left
      read_byte(`GB80_MMIO_IF);
      idle_cycle();
      idle_cycle();

      $display("errors: %0d check failures, %0d timeouts", error_count, timeout_count);
      if (error_count == 0 && timeout_count == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

/* gb80_bus_top.sv */
module gb80_bus_top
   import gb80_bus_pkg::*;
(
   input  logic       clock,
   input  logic       reset,
   input  cpu_req_t   cpu_req,
   input  logic       cpu_mem_disable,
   input  logic [7:0] ext_rdata,
   input  int_bits_t  irq,
   input  logic       int_ack,
   output ext_bus_t   ext_bus,
   output logic [7:0] rdata,
   output region_t    region,
   output logic       int_pending,
   output logic [7:0] int_vector
);

   // Router to high RAM
   logic       ram_we;
   logic [6:0] ram_offset;
   logic [7:0] ram_wdata;
   logic [7:0] ram_rdata;

   // Router to interrupt registers
   logic       flag_we;
   logic       enable_we;
   logic [7:0] reg_wdata;
   int_bits_t  int_flags;
   int_bits_t  int_enables;

   bus_router router (
      .clock           (clock),
      .reset           (reset),
      .cpu_req         (cpu_req),
      .cpu_mem_disable (cpu_mem_disable),
      .ext_rdata       (ext_rdata),
      .ram_rdata       (ram_rdata),
      .int_flags       (int_flags),
      .int_enables     (int_enables),
      .ram_we          (ram_we),
      .ram_offset      (ram_offset),
      .ram_wdata       (ram_wdata),
      .flag_we         (flag_we),
      .enable_we       (enable_we),
      .reg_wdata       (reg_wdata),
      .ext_bus         (ext_bus),
      .region          (region),
      .rdata           (rdata)
   );

   high_ram hram (
      .clock      (clock),
      .ram_we     (ram_we),
      .ram_offset (ram_offset),
      .ram_wdata  (ram_wdata),
      .ram_rdata  (ram_rdata)
   );

   interrupt_ctrl intc (
      .clock       (clock),
      .reset       (reset),
      .irq         (irq),
      .int_ack     (int_ack),
      .flag_we     (flag_we),
      .enable_we   (enable_we),
      .reg_wdata   (reg_wdata),
      .int_flags   (int_flags),
      .int_enables (int_enables),
      .int_pending (int_pending),
      .int_vector  (int_vector)
   );

endmodule

/* bus_router.sv */
`include "gb80_bus_settings.svh"

module bus_router
   import gb80_bus_pkg::*;
(
   input  logic       clock,
   input  logic       reset,
   input  cpu_req_t   cpu_req,
   input  logic       cpu_mem_disable,
   input  logic [7:0] ext_rdata,
   input  logic [7:0] ram_rdata,
   input  int_bits_t  int_flags,
   input  int_bits_t  int_enables,
   output logic       ram_we,
   output logic [6:0] ram_offset,
   output logic [7:0] ram_wdata,
   output logic       flag_we,
   output logic       enable_we,
   output logic [7:0] reg_wdata,
   output ext_bus_t   ext_bus,
   output region_t    region,
   output logic [7:0] rdata
);

   // Window limits in the split view
   localparam bus_addr_t high_start = `GB80_HIGH_START;
   localparam bus_addr_t high_end = `GB80_HIGH_END;

   logic       in_high_window;
   // Offset within the window, before trimming to 7 bits
   logic [7:0] offset_diff;
   // External strobes allowed this cycle
   logic       ext_enable;
   // Read result before the data buffer
   logic [7:0] read_mux;
   // Data buffer
   logic [7:0] rdata_q;

   // High window test on page and offset bytes
   assign in_high_window = (cpu_req.addr.split.page == high_start.split.page) &&
                           (cpu_req.addr.split.offset >= high_start.split.offset) &&
                           (cpu_req.addr.split.offset <= high_end.split.offset);

   // Region decode
   always_comb begin
      // IE sits right past the window, match it first
      if (cpu_req.addr.word == `GB80_MMIO_IE) begin
         region = REGION_IE;
      end else if (cpu_req.addr.word == `GB80_MMIO_IF) begin
         region = REGION_IF;
      end else if (in_high_window) begin
         region = REGION_HIGH;
      end else begin
         region = REGION_EXTERNAL;
      end
   end

   // RAM index
   assign offset_diff = cpu_req.addr.split.offset - high_start.split.offset;
   assign ram_offset = offset_diff[6:0];
   assign ram_wdata = cpu_req.wdata;
   assign ram_we = cpu_req.write && (region == REGION_HIGH);

   // Interrupt register writes
   assign reg_wdata = cpu_req.wdata;
   assign flag_we = cpu_req.write && (region == REGION_IF);
   assign enable_we = cpu_req.write && (region == REGION_IE);

   // External bus, same cycle as the request
   assign ext_enable = (region == REGION_EXTERNAL) && !cpu_mem_disable;

   always_comb begin
      ext_bus.addr = cpu_req.addr.word;
      ext_bus.wdata = cpu_req.wdata;
      ext_bus.we = cpu_req.write && ext_enable;
      ext_bus.re = cpu_req.read && ext_enable;
   end

   // Read source select
   always_comb begin
      case (region)
         REGION_HIGH: read_mux = ram_rdata;
         REGION_IF: read_mux = {3'b000, int_flags};
         REGION_IE: read_mux = {3'b000, int_enables};
         // Disabled external bus reads as zero
         default: read_mux = cpu_mem_disable ? 8'h00 : ext_rdata;
      endcase
   end

   // Loaded by every read, held until the next one
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         rdata_q <= 8'h00;
      end else if (cpu_req.read) begin
         rdata_q <= read_mux;
      end
   end

   assign rdata = rdata_q;

endmodule

/* high_ram.sv */
`include "gb80_bus_settings.svh"

module high_ram (
   input  logic       clock,
   input  logic       ram_we,
   input  logic [6:0] ram_offset,
   input  logic [7:0] ram_wdata,
   output logic [7:0] ram_rdata
);

   // FF80 through FFFE, offset 0 is FF80
   logic [7:0] mem [`GB80_HIGH_DEPTH];

   // Write lands at the end of the strobe cycle
   always_ff @(posedge clock) begin
      if (ram_we) begin
         mem[ram_offset] <= ram_wdata;
      end
   end

   // Combinational read
   // Router captures it into the data buffer
   assign ram_rdata = mem[ram_offset];

endmodule

/* interrupt_ctrl.sv */
`include "gb80_bus_settings.svh"

module interrupt_ctrl
   import gb80_bus_pkg::*;
(
   input  logic       clock,
   input  logic       reset,
   input  int_bits_t  irq,
   input  logic       int_ack,
   input  logic       flag_we,
   input  logic       enable_we,
   input  logic [7:0] reg_wdata,
   output int_bits_t  int_flags,
   output int_bits_t  int_enables,
   output logic       int_pending,
   output logic [7:0] int_vector
);

   // Requested and enabled sources
   logic [4:0] active;
   // Winning source index, 0 is vblank
   logic [2:0] sel_index;
   // One-hot of the winning source, zero when idle
   logic [4:0] sel_bit;
   // IF value loaded at the next edge
   int_bits_t  flags_next;

   assign active = int_flags & int_enables;

   // Anything enabled and flagged
   assign int_pending = |active;

   // Priority encoder
   always_comb begin
      sel_index = 3'd0;
      sel_bit = 5'b00000;
      // Scan from hi-lo down, last hit is the lowest set bit
      for (int i = 4; i >= 0; i--) begin
         if (active[i]) begin
            sel_index = 3'(i);
            sel_bit = 5'b00001 << i;
         end
      end
   end

   // Base plus eight times the index
   assign int_vector = `GB80_INT_VECTOR_BASE + {2'b00, sel_index, 3'b000};

   // Next IF
   always_comb begin
      if (flag_we) begin
         // CPU write to FF0F, upper three bits dropped
         flags_next = int_bits_t'(reg_wdata[4:0]);
      end else if (int_ack) begin
         // Serviced flag only, no-op when nothing pends
         flags_next = int_bits_t'(int_flags & ~sel_bit);
      end else begin
         flags_next = int_flags;
      end
      // New requests always win over clearing
      flags_next = int_bits_t'(flags_next | irq);
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         int_flags <= '0;
      end else begin
         int_flags <= flags_next;
      end
   end

   // IE only changes on a CPU write to FFFF
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         int_enables <= '0;
      end else if (enable_we) begin
         int_enables <= int_bits_t'(reg_wdata[4:0]);
      end
   end

endmodule

/* gb80_bus_pkg.sv */
package gb80_bus_pkg;

   // Page and offset bytes of an address
   typedef struct packed {
      logic [7:0] page;
      logic [7:0] offset;
   } bus_addr_split_t;

   // Whole word for exact matches, split view for the high window
   typedef union packed {
      logic [15:0]     word;
      bus_addr_split_t split;
   } bus_addr_t;

   // Interrupt sources, vblank in bit 0 and highest priority
   typedef struct packed {
      logic hilo;
      logic serial;
      logic tima;
      logic lcdc;
      logic vblank;
   } int_bits_t;

   // One CPU access, read and write are single cycle strobes
   typedef struct packed {
      bus_addr_t  addr;
      logic [7:0] wdata;
      logic       read;
      logic       write;
   } cpu_req_t;

   // External memory strobes
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  wdata;
      logic        we;
      logic        re;
   } ext_bus_t;

   // Target of an access
   typedef enum logic [1:0] {
      REGION_EXTERNAL,
      REGION_HIGH,
      REGION_IF,
      REGION_IE
   } region_t;

endpackage

/* gb80_bus_settings.svh */
`ifndef GB80_BUS_SETTINGS_SVH
`define GB80_BUS_SETTINGS_SVH

// High memory window, internal RAM only
`define GB80_HIGH_START 16'hff80
`define GB80_HIGH_END 16'hfffe

// Memory mapped interrupt registers
`define GB80_MMIO_IF 16'hff0f
`define GB80_MMIO_IE 16'hffff

// One byte per address in the window
`define GB80_HIGH_DEPTH 127

// Vector of vblank, each lower priority source adds 8
`define GB80_INT_VECTOR_BASE 8'h40

`endif
